// ==== divider_settings.svh ====
`ifndef DIVIDER_SETTINGS_SVH
`define DIVIDER_SETTINGS_SVH

// Operand and result width
`define XLEN 32

// Residual word of the recurrence
// Sign, two integer bits and XLEN+1 fraction bits
// The register keeps the residual already doubled
`define RESW (`XLEN + 4)

// Step counter width
// Must hold up to XLEN+1 steps
// Also used for the leading-zero counts
`define STEPW ($clog2(`XLEN + 2))

`endif

// ==== dividerPkg.sv ====
`include "divider_settings.svh"

package dividerPkg;

  // Residual word of the SRT recurrence
  // Read as one two's complement number for the remainder arithmetic
  // or split into sign and magnitude for the negative-residual test
  typedef union packed {
    logic signed [`RESW-1:0] value;
    struct packed {
      // Set when the residual is negative
      logic             sign;
      // Remaining integer and fraction bits
      logic [`RESW-2:0] mag;
    } parts;
  } divResidual_t;

endpackage

// ==== divDatapathIf.sv ====
`include "divider_settings.svh"

// Datapath state handed from the recurrence to postprocessing
interface divDatapathIf;

  // Carry-save residual pair, doubled form
  logic [`RESW-1:0] ws;
  logic [`RESW-1:0] wc;

  // Normalized divisor in the residual format
  logic [`RESW-1:0] d;

  // On-the-fly quotient and quotient minus one
  logic [`XLEN-1:0] u;
  logic [`XLEN-1:0] um;

  // One-cycle pulse after the last step
  logic             finish;

  //////////////////////////////
  // Producer side
  //////////////////////////////
  modport iteration (
    output ws, wc, d, u, um, finish
  );

  //////////////////////////////
  // Consumer side
  //////////////////////////////
  modport postproc (
    input ws, wc, d, u, um, finish
  );

endinterface

// ==== divPreproc.sv ====
`include "divider_settings.svh"

module divPreproc (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  logic                     signedOp,
  input  logic                     remOp,
  input  logic [`XLEN-1:0]         a,
  input  logic [`XLEN-1:0]         b,
  input  logic                     busy,
  output logic                     load,
  output logic [`XLEN-1:0]         normA,
  output logic [`XLEN-1:0]         normB,
  output logic [`STEPW-1:0]        steps,
  output logic [$clog2(`XLEN)-1:0] remShift,
  output logic                     divByZero,
  output logic                     overflow,
  output logic                     aLessB,
  output logic                     negQuot,
  output logic                     negRem,
  output logic                     remOpHeld,
  output logic [`XLEN-1:0]         aHeld
);

  localparam logic [`STEPW-1:0] oneStep = 1;

  // Count of zeros above the leading one, XLEN for a zero word
  function automatic logic [`STEPW-1:0] leadingZeros(input logic [`XLEN-1:0] x);
    logic [`STEPW-1:0] count;
    logic              found;
    count = '0;
    found = 1'b0;
    for (int i = `XLEN - 1; i >= 0; i--) begin
      if (x[i]) begin
        found = 1'b1;
      end else if (!found) begin
        count = count + oneStep;
      end
    end
    return count;
  endfunction

  logic              aNeg;
  logic              bNeg;
  logic [`XLEN-1:0]  aMag;
  logic [`XLEN-1:0]  bMag;
  logic [`STEPW-1:0] aZeros;
  logic [`STEPW-1:0] bZeros;
  logic              zeroDivisor;
  logic              signedOverflow;
  logic              smallDividend;

  // Magnitudes, the most negative value maps onto itself as unsigned
  assign aNeg = signedOp & a[`XLEN-1];
  assign bNeg = signedOp & b[`XLEN-1];
  assign aMag = aNeg ? -a : a;
  assign bMag = bNeg ? -b : b;
  assign aZeros = leadingZeros(aMag);
  assign bZeros = leadingZeros(bMag);

  // RISC-V special cases
  assign zeroDivisor = (b == '0);
  assign signedOverflow = signedOp & (a == {1'b1, {(`XLEN-1){1'b0}}}) & (&b);
  assign smallDividend = (aMag < bMag);

  // Accepted start, ignored while an operation is in flight
  assign load = start & ~busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      divByZero <= 1'b0;
      overflow  <= 1'b0;
      aLessB    <= 1'b0;
    end else if (load) begin
      divByZero <= zeroDivisor;
      overflow  <= signedOverflow;
      aLessB    <= smallDividend & ~zeroDivisor;
    end
  end

  // MSB-aligned operands, one step per bit of excess plus one
  always_ff @(posedge clk) begin
    if (load) begin
      normA     <= aMag << aZeros;
      normB     <= bMag << bZeros;
      steps     <= (zeroDivisor | signedOverflow | smallDividend) ? '0
                                                                  : bZeros - aZeros + oneStep;
      remShift  <= bZeros[$clog2(`XLEN)-1:0];
      negQuot   <= aNeg ^ bNeg;
      negRem    <= aNeg;
      remOpHeld <= remOp;
      aHeld     <= a;
    end
  end

endmodule

// ==== divIteration.sv ====
`include "divider_settings.svh"

module divIteration import dividerPkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              load,
  input  logic              done,
  input  logic [`XLEN-1:0]  normA,
  input  logic [`XLEN-1:0]  normB,
  input  logic [`STEPW-1:0] steps,
  output logic              busy,
  divDatapathIf.iteration   dp
);

  localparam logic [`STEPW-1:0] oneStep = 1;

  divResidual_t      ws;
  divResidual_t      wc;
  logic [`RESW-1:0]  d;
  logic [`XLEN-1:0]  u;
  logic [`XLEN-1:0]  um;
  logic [`STEPW-1:0] count;
  logic              init;
  logic              active;
  logic              finish;
  logic [3:0]        estimate;
  logic              qPos;
  logic              qNeg;
  logic              qZero;
  logic [`RESW-1:0]  dTerm;
  logic [`RESW-1:0]  sumBits;
  logic [`RESW-1:0]  majBits;
  logic [`RESW-1:0]  carryBits;
  logic [`XLEN-1:0]  uNext;
  logic [`XLEN-1:0]  umNext;

  //////////////////////////////
  // Quotient digit selection
  //////////////////////////////

  // Truncated sum of the top bits, sign plus one fraction bit of 2w
  assign estimate = ws.value[`RESW-1 -: 4] + wc.value[`RESW-1 -: 4];
  // -1/2 selects zero, other negatives select -1
  assign qZero = &estimate;
  assign qPos  = ~estimate[3];
  assign qNeg  = estimate[3] & ~qZero;

  //////////////////////////////
  // Carry-save residual update
  //////////////////////////////

  // Subtract D as ~D plus a carry-in on the free carry LSB
  assign dTerm     = qPos ? ~d : (qNeg ? d : '0);
  assign sumBits   = ws.value ^ wc.value ^ dTerm;
  assign majBits   = (ws.value & wc.value) | (ws.value & dTerm) | (wc.value & dTerm);
  assign carryBits = {majBits[`RESW-2:0], qPos};

  // On-the-fly conversion keeps U and U-1 without a carry chain
  always_comb begin
    if (qPos) begin
      uNext  = {u[`XLEN-2:0], 1'b1};
      umNext = {u[`XLEN-2:0], 1'b0};
    end else if (qNeg) begin
      uNext  = {um[`XLEN-2:0], 1'b1};
      umNext = {um[`XLEN-2:0], 1'b0};
    end else begin
      uNext  = {u[`XLEN-2:0], 1'b0};
      umNext = {um[`XLEN-2:0], 1'b1};
    end
  end

  assign active = (count != '0);

  //////////////////////////////
  // Step control
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      busy   <= 1'b0;
      init   <= 1'b0;
      count  <= '0;
      finish <= 1'b0;
    end else begin
      finish <= 1'b0;
      if (load) begin
        busy <= 1'b1;
        init <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
      // Zero steps means a special case, finish right away
      if (init) begin
        init   <= 1'b0;
        count  <= steps;
        finish <= (steps == '0);
      end else if (active) begin
        count  <= count - oneStep;
        finish <= (count == oneStep);
      end
    end
  end

  // Residual starts as X, which is w0 = X/2 already doubled
  always_ff @(posedge clk) begin
    if (init) begin
      ws.value <= {3'b000, normA, 1'b0};
      wc.value <= '0;
      d        <= {3'b000, normB, 1'b0};
      u        <= '0;
      um       <= '1;
    end else if (active) begin
      ws.value <= {sumBits[`RESW-2:0], 1'b0};
      wc.value <= {carryBits[`RESW-2:0], 1'b0};
      u        <= uNext;
      um       <= umNext;
    end
  end

  assign dp.ws     = ws.value;
  assign dp.wc     = wc.value;
  assign dp.d      = d;
  assign dp.u      = u;
  assign dp.um     = um;
  assign dp.finish = finish;

endmodule

// ==== divPostproc.sv ====
`include "divider_settings.svh"

module divPostproc import dividerPkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  divDatapathIf.postproc           dp,
  input  logic                     divByZero,
  input  logic                     overflow,
  input  logic                     aLessB,
  input  logic                     negQuot,
  input  logic                     negRem,
  input  logic                     remOp,
  input  logic [$clog2(`XLEN)-1:0] remShift,
  input  logic [`XLEN-1:0]         aHeld,
  output logic                     done,
  output logic [`XLEN-1:0]         result,
  output logic                     exact
);

  // x + y == 0 without a carry chain
  function automatic logic sumIsZero(input logic [`RESW-1:0] x, input logic [`RESW-1:0] y);
    return (x ^ y) == {x[`RESW-2:0] | y[`RESW-2:0], 1'b0};
  endfunction

  divResidual_t     resSum;
  logic [`RESW-1:0] d2;
  logic [`RESW-1:0] fixSum;
  logic [`RESW-1:0] fixMaj;
  logic [`RESW-1:0] fixCarry;
  logic [`RESW-1:0] remFull;
  logic             negResidual;
  logic             resZero;
  logic             specialCase;
  logic             sticky;
  logic [`XLEN-1:0] quotMag;
  logic [`XLEN-1:0] remMag;
  logic [`XLEN-1:0] quotSigned;
  logic [`XLEN-1:0] remSigned;
  logic [`XLEN-1:0] preResult;
  logic [`XLEN-1:0] specRem;
  logic [`XLEN-1:0] specResult;

  //////////////////////////////
  // Exact result detect
  //////////////////////////////

  // Register pair holds 2w, so the divisor enters doubled
  assign d2 = {dp.d[`RESW-2:0], 1'b0};

  // Residual of -D also leaves a zero remainder after correction
  assign fixSum   = dp.ws ^ dp.wc ^ d2;
  assign fixMaj   = (dp.ws & dp.wc) | (dp.ws & d2) | (dp.wc & d2);
  assign fixCarry = {fixMaj[`RESW-2:0], 1'b0};
  assign resZero  = sumIsZero(dp.ws, dp.wc) | sumIsZero(fixSum, fixCarry);

  //////////////////////////////
  // Sign correction
  //////////////////////////////
  assign resSum.value = dp.ws + dp.wc;
  assign negResidual  = resSum.parts.sign;

  // Negative residual means the quotient overshot by one
  assign quotMag = negResidual ? dp.um : dp.u;
  assign remFull = resSum.value + (negResidual ? d2 : '0);

  // Drop the doubling and fraction offset, then undo the divisor shift
  assign remMag = remFull[`XLEN+1:2] >> remShift;

  assign quotSigned = negQuot ? -quotMag : quotMag;
  assign remSigned  = negRem ? -remMag : remMag;
  assign preResult  = remOp ? remSigned : quotSigned;

  //////////////////////////////
  // RISC-V special cases
  //////////////////////////////
  assign specialCase = divByZero | overflow | aLessB;
  assign specRem     = overflow ? '0 : aHeld;

  always_comb begin
    if (divByZero) begin
      // Quotient all ones, remainder the dividend
      specResult = remOp ? aHeld : '1;
    end else if (overflow) begin
      specResult = remOp ? '0 : aHeld;
    end else begin
      specResult = remOp ? aHeld : '0;
    end
  end

  // Sticky when any remainder is left
  assign sticky = specialCase ? (specRem != '0) : ~resZero;

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= dp.finish;
    end
  end

  always_ff @(posedge clk) begin
    if (dp.finish) begin
      result <= specialCase ? specResult : preResult;
      exact  <= ~sticky;
    end
  end

endmodule

// ==== divider.sv ====
`include "divider_settings.svh"

module divider (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic             signedOp,
  input  logic             remOp,
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  output logic             busy,
  output logic             done,
  output logic [`XLEN-1:0] result,
  output logic             exact
);

  logic                     load;
  logic [`XLEN-1:0]         normA;
  logic [`XLEN-1:0]         normB;
  logic [`STEPW-1:0]        steps;
  logic [$clog2(`XLEN)-1:0] remShift;
  logic                     divByZero;
  logic                     overflow;
  logic                     aLessB;
  logic                     negQuot;
  logic                     negRem;
  logic                     remOpHeld;
  logic [`XLEN-1:0]         aHeld;

  // Residual and quotient from the recurrence to postprocessing
  divDatapathIf dpIf ();

  // Operand capture and normalization
  divPreproc preprocInst (
    .clk, .reset, .start, .signedOp, .remOp, .a, .b, .busy,
    .load, .normA, .normB, .steps, .remShift,
    .divByZero, .overflow, .aLessB, .negQuot, .negRem, .remOpHeld, .aHeld
  );

  // SRT recurrence, busy is cleared by done
  divIteration iterationInst (
    .clk, .reset, .load, .done, .normA, .normB, .steps, .busy,
    .dp(dpIf)
  );

  // Correction, special cases and result register
  divPostproc postprocInst (
    .clk, .reset, .dp(dpIf),
    .divByZero, .overflow, .aLessB, .negQuot, .negRem,
    .remOp(remOpHeld), .remShift, .aHeld,
    .done, .result, .exact
  );

endmodule

// ==== divider_checker.sv ====
module divider_checker (
  input logic clk,
  input logic reset,
  input logic start,
  input logic busy,
  input logic done
);

  // done is a single-cycle pulse
  doneSingle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // done only ends an operation in flight
  doneAfterBusy: assert property (@(posedge clk) disable iff (reset) done |-> $past(busy))
    else $error("done without busy in the previous cycle");

  // Idle right after reset
  idleAfterReset: assert property (@(posedge clk) $fell(reset) |-> !busy && !done)
    else $error("busy or done high after reset");

  // Start during an operation is ignored until done ends it
  startWhileBusy: assert property (@(posedge clk) disable iff (reset)
                                   start && busy && !done |=> busy)
    else $error("start while busy dropped busy");

endmodule

bind divider divider_checker checkerInst (
  .clk(clk),
  .reset(reset),
  .start(start),
  .busy(busy),
  .done(done)
);

// ==== dividerTb.sv ====
`include "divider_settings.svh"

module dividerTb;

  localparam int randomOps = 10000;
  // Headroom of 300 operations for the directed part
  // Each operation takes at most XLEN+8 cycles
  localparam int cycleLimit = (randomOps + 300) * (`XLEN + 8);
  localparam logic [`XLEN-1:0] minInt = {1'b1, {(`XLEN-1){1'b0}}};

  logic             clk;
  logic             reset;
  logic             start;
  logic             signedOp;
  logic             remOp;
  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic             busy;
  logic             done;
  logic [`XLEN-1:0] result;
  logic             exact;

  // Queue of accepted {signedOp, remOp, a, b} with the oldest first
  logic [2*`XLEN+1:0] pending[$];
  logic [2*`XLEN+1:0] entry;
  logic [`XLEN-1:0]   expResult;
  logic               expExact;
  logic [31:0]        rngState;
  logic [31:0]        rawA;
  logic [31:0]        rawB;
  int                 cycles = 0;
  int                 checks = 0;
  int                 resultErrors = 0;
  int                 exactErrors = 0;
  int                 protocolErrors = 0;
  int                 strayDones = 0;
  bit                 timedOut = 1'b0;

  divider divider_inst (
    .clk, .reset, .start, .signedOp, .remOp, .a, .b,
    .busy, .done, .result, .exact
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // RISC-V DIV, DIVU, REM and REMU
  function automatic logic [`XLEN-1:0] refDiv(input logic [`XLEN-1:0] x,
                                              input logic [`XLEN-1:0] y,
                                              input logic s, input logic r);
    longint nx;
    longint ny;
    longint q;
    longint m;
    if (y == '0) begin
      return r ? x : '1;
    end
    if (s && x == minInt && y == '1) begin
      return r ? '0 : x;
    end
    nx = s ? {{(64-`XLEN){x[`XLEN-1]}}, x} : {{(64-`XLEN){1'b0}}, x};
    ny = s ? {{(64-`XLEN){y[`XLEN-1]}}, y} : {{(64-`XLEN){1'b0}}, y};
    // Division truncates toward zero
    // The remainder keeps the dividend sign
    q = nx / ny;
    m = nx % ny;
    return r ? m[`XLEN-1:0] : q[`XLEN-1:0];
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Random magnitude range so that every step count shows up
  function automatic logic [`XLEN-1:0] scaledOperand(input logic [31:0] raw,
                                                     input logic [4:0] shift, input logic negate);
    return negate ? -(raw >> shift) : (raw >> shift);
  endfunction

  task automatic waitIdle();
    while (!done) @(negedge clk);
    while (busy) @(negedge clk);
  endtask

  // Called on a falling edge with busy low
  task automatic runOp(input logic [`XLEN-1:0] opA, input logic [`XLEN-1:0] opB,
                       input logic s, input logic r);
    a = opA;
    b = opB;
    signedOp = s;
    remOp = r;
    start = 1'b1;
    pending.push_back({s, r, opA, opB});
    @(negedge clk);
    start = 1'b0;
    waitIdle();
  endtask

  // Second start lands while busy and must leave no trace
  task automatic runOpWithLateStart(input logic [`XLEN-1:0] opA, input logic [`XLEN-1:0] opB,
                                    input logic s, input logic r);
    a = opA;
    b = opB;
    signedOp = s;
    remOp = r;
    start = 1'b1;
    pending.push_back({s, r, opA, opB});
    @(negedge clk);
    if (!busy) begin
      protocolErrors++;
      $display("busy did not rise after an accepted start at time %0t", $time);
    end
    a = ~opA;
    b = opB + 1;
    signedOp = ~s;
    remOp = ~r;
    @(negedge clk);
    start = 1'b0;
    waitIdle();
    // A second done would show up here as a stray pulse
    repeat (`XLEN + 8) @(negedge clk);
  endtask

  task automatic runAllModes(input logic [`XLEN-1:0] opA, input logic [`XLEN-1:0] opB);
    for (int m = 0; m < 4; m++) begin
      runOp(opA, opB, m[1], m[0]);
    end
  endtask

  task automatic finishRun();
    $display("%0d checks, errors: %0d result %0d exact %0d protocol %0d stray, timeout %0b",
             checks, resultErrors, exactErrors, protocolErrors, strayDones, timedOut);
    if (!timedOut && resultErrors == 0 && exactErrors == 0 && protocolErrors == 0 &&
        strayDones == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  //////////////////////////////
  // Comparison on each done
  //////////////////////////////
  always @(negedge clk) begin
    if (!reset && done) begin
      if (pending.size() == 0) begin
        strayDones++;
        $display("done at time %0t without an accepted operation", $time);
      end else begin
        entry = pending.pop_front();
        expResult = refDiv(entry[2*`XLEN-1:`XLEN], entry[`XLEN-1:0],
                           entry[2*`XLEN+1], entry[2*`XLEN]);
        expExact = (refDiv(entry[2*`XLEN-1:`XLEN], entry[`XLEN-1:0],
                           entry[2*`XLEN+1], 1'b1) == '0);
        checks++;
        if (result !== expResult) begin
          resultErrors++;
          $display("** Error at %0t: signed=%0b rem=%0b a=%h b=%h result %h, expected %h",
                   $time, entry[2*`XLEN+1], entry[2*`XLEN], entry[2*`XLEN-1:`XLEN],
                   entry[`XLEN-1:0], result, expResult);
        end
        if (exact !== expExact) begin
          exactErrors++;
          $display("** Error at %0t: a=%h b=%h exact %b, expected %b",
                   $time, entry[2*`XLEN-1:`XLEN], entry[`XLEN-1:0], exact, expExact);
        end
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit) begin
      timedOut = 1'b1;
      $display("Run stopped after %0d cycles without finishing", cycles);
      finishRun();
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    reset = 1'b1;
    start = 1'b0;
    signedOp = 1'b0;
    remOp = 1'b0;
    a = '0;
    b = '0;
    rngState = 32'h1334_4143;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // Sign combinations with exact and inexact results
    runAllModes(32'd100, 32'd7);
    runAllModes(-32'd100, 32'd7);
    runAllModes(32'd100, -32'd7);
    runAllModes(-32'd100, -32'd7);
    runAllModes(32'd1000, 32'd10);
    runAllModes(-32'd1000, 32'd10);
    runAllModes(32'd37, 32'd6);
    runAllModes(32'd7, 32'd7);
    runAllModes(32'd1, 32'd1);
    runAllModes(32'hDEAD_BEEF, 32'h0000_1234);
    runAllModes(32'h00FF_FFFF, 32'h0000_0FFF);
    runAllModes(32'h7FFF_FFFF, 32'd2);
    runAllModes(32'hFFFF_FFFF, 32'd1);
    runAllModes(32'hFFFF_FFFF, 32'hFFFF_FFFF);
    // Most negative dividend, overflow and divisor edge values
    runAllModes(minInt, 32'hFFFF_FFFF);
    runAllModes(minInt, 32'd1);
    runAllModes(minInt, 32'd2);
    runAllModes(32'h1234_5678, minInt);
    // Division by zero and small dividends
    runAllModes(32'd5, 32'd0);
    runAllModes(32'd0, 32'd0);
    runAllModes(minInt, 32'd0);
    runAllModes(32'd3, 32'd10);
    runAllModes(-32'd3, 32'd10);
    runAllModes(32'd0, 32'd5);

    runOpWithLateStart(32'd1000, 32'd3, 1'b1, 1'b0);
    runOpWithLateStart(32'd9, 32'd0, 1'b0, 1'b1);

    for (int i = 0; i < randomOps; i++) begin
      rngState = xorshift(rngState);
      rawA = rngState;
      rngState = xorshift(rngState);
      rawB = rngState;
      rngState = xorshift(rngState);
      runOp(scaledOperand(rawA, rngState[4:0], rngState[12]),
            scaledOperand(rawB, rngState[9:5], rngState[13]), rngState[10], rngState[11]);
    end

    repeat (`XLEN + 8) @(negedge clk);
    if (pending.size() != 0) begin
      protocolErrors++;
      $display("%0d accepted operations never returned done", pending.size());
    end
    finishRun();
  end

endmodule

// ==== build.f ====
+incdir+.
dividerPkg.sv
divDatapathIf.sv
divPreproc.sv
divIteration.sv
divPostproc.sv
divider.sv
divider_checker.sv
dividerTb.sv

// ==== Makefile ====
TOP = dividerTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
